// ==== Bender.yml ====
package:
  name: norm_round

sources:
  - files:
      - verilog/fpnorm_pkg.sv
      - verilog/norm_special_case.sv
      - verilog/norm_shift.sv
      - verilog/norm_round.sv
      - verilog/norm_pack.sv
      - verilog/norm_round_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/norm_round_tb.sv

// ==== src.f ====
+incdir+include
verilog/fpnorm_pkg.sv
verilog/norm_special_case.sv
verilog/norm_shift.sv
verilog/norm_round.sv
verilog/norm_pack.sv
verilog/norm_round_top.sv
verif/norm_round_tb.sv

// ==== include/norm_ref_model.svh ====
`ifndef NORM_REF_MODEL_SVH
`define NORM_REF_MODEL_SVH

typedef struct packed {
  fp_result_u result;
  fflags_t    fflags;
} ref_out_t;

// Special-case chain as a priority case
function automatic special_res_t ref_special(logic sign, op_ctl_t ctl, operand_class_t cls);
  special_res_t s;
  s = '{hit: 1'b1, mant: {1'b0, C_MANT_NAN_FP64}, exp: '1, sign: 1'b0, flags: '0};
  case (1'b1)
    cls.nan_a, cls.nan_b: s.flags.nv = cls.snan;
    cls.inf_a:
    begin
      if ((ctl.div_en && cls.inf_b) || (ctl.sqrt_en && sign))
        s.flags.nv = 1'b1;
      else
        s = '{hit: 1'b1, mant: '0, exp: '1, sign: sign, flags: 5'b00100};
    end
    ctl.div_en && cls.inf_b: s = '{hit: 1'b1, mant: '0, exp: '0, sign: sign, flags: 5'b00100};
    cls.zero_a:
    begin
      if (ctl.div_en)
        s.flags = {1'b1, !cls.zero_b, 3'b000};
      else
        s = '{hit: 1'b1, mant: '0, exp: '0, sign: sign, flags: '0};
    end
    ctl.div_en && cls.zero_b: s = '{hit: 1'b1, mant: '0, exp: '1, sign: sign, flags: 5'b01000};
    ctl.sqrt_en && sign: s.flags.nv = 1'b1;
    default: s.hit = 1'b0;
  endcase
  return s;
endfunction

// Normalization as one shift of a 110-bit window
function automatic norm_stage_t ref_normalize(norm_in_t d, op_ctl_t ctl, special_res_t s);
  norm_stage_t  n;
  logic [109:0] wide;
  int           e;
  int           shr;      // Negative means one step left
  logic         of_bit;
  logic         max_exp;
  n                = '0;
  n.rm             = ctl.rm;
  n.full_precision = ctl.full_precision;
  n.fmt            = ctl.fmt;
  n.sign           = d.sign;
  if (s.hit)
  begin
    n.mant_norm = s.mant;
    n.exp_norm  = s.exp;
    n.sign      = s.sign;
    n.flags     = s.flags;
    return n;
  end
  e       = int'(d.exp);
  of_bit  = (ctl.fmt == FMT_FP32) ? d.exp[C_EXP_FP32] : d.exp[C_EXP_FP64];
  max_exp = (ctl.fmt == FMT_FP32) ? (d.exp[7:0] == 8'hff) : (d.exp[10:0] == 11'h7ff);
  shr     = 0;
  if (d.exp[C_EXP_FP64:0] == '0)
  begin
    n.flags.uf = (d.mant != '0);
    shr        = 1;
  end
  else if ((d.exp[C_EXP_FP64:0] == C_EXP_ONE_FP64) && !d.mant[C_MANT_W-1])
    n.flags.uf = 1'b1;
  else if (e < 0)
  begin
    n.flags.uf = 1'b1;
    shr        = 1 - e;
  end
  else if (of_bit || (max_exp && d.mant[C_MANT_W-1]))
  begin
    n.exp_norm = '1;
    n.flags.of = 1'b1;
    return n;
  end
  else if (d.mant[C_MANT_W-1])
    n.exp_norm = e[10:0];
  else
  begin
    n.exp_norm = 11'(e - 1);
    shr        = -1;
  end
  wide            = {d.mant, 53'b0};
  wide            = (shr < 0) ? (wide << 1) : (wide >> shr);
  n.mant_norm     = wide[109:57];
  n.mant_forround = wide[56:0];
  return n;
endfunction

// Rounding by dropped-bit count
function automatic rounded_t ref_round(norm_stage_t n);
  logic [109:0] full;
  logic [53:0]  kept;
  logic [53:0]  sum;
  logic         guard;
  logic         rest;
  logic         up;
  int           drop;
  rounded_t     r;
  full  = (n.fmt == FMT_FP64) ? {n.mant_norm, n.mant_forround} : {n.mant_norm, 57'b0};
  drop  = (n.fmt == FMT_FP64) ? 57 : 57 + C_FP32_LSB;
  kept  = 54'(full >> drop);
  guard = full[drop-1];
  rest  = |(full & ((110'd1 << (drop - 1)) - 110'd1));
  case (n.rm)
    RM_NEAREST:  up = guard & (rest | kept[0]);
    RM_PLUSINF:  up = (guard | rest) & ~n.sign;
    RM_MINUSINF: up = (guard | rest) & n.sign;
    default:     up = 1'b0;
  endcase
  sum       = (kept + up) << (drop - 57);
  r.mant    = sum[53] ? sum[52:1] : sum[51:0];
  r.exp     = n.exp_norm + sum[53];
  r.inexact = guard | rest;
  return r;
endfunction

// Full expected result and flags
function automatic ref_out_t ref_model(norm_in_t d, op_ctl_t ctl, operand_class_t cls);
  norm_stage_t n;
  rounded_t    r;
  ref_out_t    o;
  logic [51:0] mant;
  logic [10:0] exp;
  n    = ref_normalize(d, ctl, ref_special(d.sign, ctl, cls));
  r    = ref_round(n);
  mant = ctl.full_precision ? r.mant : n.mant_norm[51:0];
  exp  = ctl.full_precision ? r.exp : n.exp_norm;
  if (ctl.fmt == FMT_FP64)
    o.result = {n.sign, exp, mant};
  else
    o.result = {C_FP32_BOX, n.sign, exp[7:0], mant[51:29]};
  o.fflags    = n.flags;
  o.fflags.nx = !ctl.full_precision || r.inexact;
  return o;
endfunction

`endif

// ==== verif/norm_round_tb.sv ====
`timescale 1ns/100ps

module norm_round_tb import fpnorm_pkg::*;
();

  //////////////////////////////////////////////////
  // Test lengths and run limit
  //////////////////////////////////////////////////
  localparam int C_RST_CYCLES = 16;
  localparam int C_N_SPEC     = 200;
  localparam int C_N_FP64     = 400;
  localparam int C_N_FP32     = 300;
  localparam int C_N_UF       = 300;
  localparam int C_N_TRUNC    = 200;
  localparam int C_N_PIPE     = 400;
  localparam int C_N_ALL      = C_N_SPEC + C_N_FP64 + C_N_FP32 + C_N_UF + C_N_TRUNC + C_N_PIPE;
  // At most two cycles per item, a short drain per test, then margin
  localparam int C_TIMEOUT    = C_RST_CYCLES + 2 * C_N_ALL + 6 * 10 + 50;

  `include "norm_ref_model.svh"

  logic           clk;
  logic           rst;
  logic           in_valid;
  norm_in_t       in_data;
  op_ctl_t        in_ctl;
  operand_class_t in_class;
  logic           out_valid;
  fp_result_u     out_result;
  fflags_t        out_fflags;

  logic [31:0] seed = 32'hb188;
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          test_idx = 0;
  int          test_err0 = 0;
  ref_out_t    exp_q[$];     // Expected results in issue order
  int          due_q[$];     // Negedge cycle each result is due
  ref_out_t    mon_exp;
  int          mon_due;

  norm_round_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ctl     (in_ctl),
    .in_class   (in_class),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_fflags (out_fflags)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  always @(posedge clk)
  begin
    if (cycle >= C_TIMEOUT)
    begin
      $display("Timeout after %0d cycles, %0d results still outstanding", cycle, exp_q.size());
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Random helpers
  //////////////////////////////////////////////////
  function automatic logic [15:0] rand_hi();
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
    return seed[31:16];                          // Upper half, better period
  endfunction

  function automatic logic [C_MANT_W-1:0] rand_mant();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [15:0] d;
    a = rand_hi();
    b = rand_hi();
    c = rand_hi();
    d = rand_hi();
    return {a[8:0], b, c, d};  // 57 bits
  endfunction

  function automatic logic signed [C_EXP_W-1:0] rand_exp(fmt_e fmt);
    logic [15:0] r;
    r = rand_hi();
    if (fmt == FMT_FP64)
      return C_EXP_W'(1 + r % 2046);  // Normal FP64 range
    return C_EXP_W'(1 + r % 300);     // Reaches the FP32 overflow bit
  endfunction

  function automatic op_ctl_t make_ctl(fmt_e fmt, logic full_precision);
    op_ctl_t     c;
    logic [15:0] r;
    r                = rand_hi();
    c.div_en         = r[15];
    c.sqrt_en        = r[14] & ~r[15];
    c.rm             = rm_e'({1'b0, r[13:12]});  // The four defined modes
    c.full_precision = full_precision;
    c.fmt            = fmt;
    return c;
  endfunction

  //////////////////////////////////////////////////
  // Driving and checking
  //////////////////////////////////////////////////
  task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, expected);
    end
  endtask

  task automatic drive_item(norm_in_t d, op_ctl_t c, operand_class_t k);
    @(posedge clk);
    in_valid <= 1'b1;
    in_data  <= d;
    in_ctl   <= c;
    in_class <= k;
    exp_q.push_back(ref_model(d, c, k));
    due_q.push_back(cycle + 3);  // Taken next edge, out two edges later
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic start_test();
    test_idx++;
    test_err0 = errors;
  endtask

  task automatic finish_test(string name);
    idle();
    while (exp_q.size() != 0)
      @(posedge clk);
    $display("Test %0d %-12s %s, %0d errors", test_idx, name,
             (errors == test_err0) ? "passed" : "failed", errors - test_err0);
  endtask

  // Result monitor, outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (out_valid)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("Output at t=%0t with no input waiting for it", $time);
        end
        else
        begin
          mon_exp = exp_q.pop_front();
          mon_due = due_q.pop_front();
          if (mon_due != cycle)
          begin
            errors++;
            $display("Output at cycle %0d was due at cycle %0d", cycle, mon_due);
          end
          check_value("out_result", out_result, mon_exp.result);
          check_value("out_fflags", 64'(out_fflags), 64'(mon_exp.fflags));
        end
      end
      else if (exp_q.size() != 0 && due_q[0] <= cycle)
      begin
        errors++;
        $display("No output at cycle %0d for the input due then", due_q[0]);
        mon_exp = exp_q.pop_front();
        mon_due = due_q.pop_front();
      end
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_special(int n);
    norm_in_t       d;
    op_ctl_t        c;
    operand_class_t k;
    logic [15:0]    r1;
    logic [15:0]    r2;
    start_test();
    for (int i = 0; i < n; i++)
    begin
      r1     = rand_hi();
      r2     = rand_hi();
      k      = operand_class_t'(r1[6:0] & r2[6:0]);  // Sparse flags, many hits
      d.mant = rand_mant();
      d.exp  = C_EXP_W'(r1[15:8]) + C_EXP_W'(r2[15:8]);
      d.sign = r2[7];
      c      = make_ctl(fmt_e'(r1[7]), r2[12]);
      drive_item(d, c, k);
    end
    finish_test("special");
  endtask

  // Rounding of 1.x normals, top bits all ones now and then for a carry
  task automatic test_round(int n, fmt_e fmt, string name);
    norm_in_t    d;
    op_ctl_t     c;
    logic [15:0] r;
    start_test();
    for (int i = 0; i < n; i++)
    begin
      r                   = rand_hi();
      d.mant              = rand_mant();
      d.mant[C_MANT_W-1]  = 1'b1;
      if (r[15:13] == 3'd0)
        d.mant[C_MANT_W-1:33] = '1;     // Carry at the FP32 point
      else if (r[15:13] == 3'd1)
        d.mant[C_MANT_W-1:4] = '1;      // Carry at the FP64 point
      d.exp  = rand_exp(fmt);
      d.sign = r[12];
      c      = make_ctl(fmt, 1'b1);
      c.sqrt_en = 1'b0;                 // Keeps negative values off the NaN path
      drive_item(d, c, operand_class_t'(0));
    end
    finish_test(name);
  endtask

  task automatic test_underflow(int n);
    norm_in_t    d;
    op_ctl_t     c;
    logic [15:0] r;
    start_test();
    for (int i = 0; i < n; i++)
    begin
      r      = rand_hi();
      d.mant = rand_mant();
      d.sign = r[15];
      case (r % 3)
        0: d.exp = '0;                     // Shift by five
        1:
        begin
          d.exp              = C_EXP_W'(1);
          d.mant[C_MANT_W-1] = 1'b0;       // Shift by four
        end
        default: d.exp = -C_EXP_W'(1 + (r[14:4] % 80));
      endcase
      c         = make_ctl(fmt_e'(r[3]), 1'b1);
      c.sqrt_en = 1'b0;
      drive_item(d, c, operand_class_t'(0));
    end
    finish_test("underflow");
  endtask

  task automatic test_trunc(int n);
    norm_in_t    d;
    op_ctl_t     c;
    logic [15:0] r;
    start_test();
    for (int i = 0; i < n; i++)
    begin
      r                  = rand_hi();
      d.mant             = rand_mant();
      d.mant[C_MANT_W-1] = r[14];          // Both 1.x and 0.1x
      d.mant[C_MANT_W-2] = 1'b1;
      d.exp              = rand_exp(fmt_e'(r[15]));
      d.sign             = r[13];
      c                  = make_ctl(fmt_e'(r[15]), 1'b0);
      c.sqrt_en          = 1'b0;
      drive_item(d, c, operand_class_t'(0));
    end
    finish_test("truncate");
  endtask

  task automatic test_pipeline(int n);
    norm_in_t       d;
    op_ctl_t        c;
    operand_class_t k;
    logic [15:0]    r;
    start_test();
    for (int i = 0; i < n; i++)
    begin
      r = rand_hi();
      if (r[15:13] == 3'd0)
        k = operand_class_t'(rand_hi());
      else
        k = operand_class_t'(0);
      d.mant = rand_mant();
      d.exp  = C_EXP_W'(rand_hi());      // Any exponent, sign included
      d.sign = r[12];
      c      = make_ctl(fmt_e'(r[11]), r[10]);
      c.rm   = rm_e'(r[9:7]);             // Unused codes too
      drive_item(d, c, k);
      if (r[6])
        idle();                           // Bubble
    end
    finish_test("pipeline");
  endtask

  initial
  begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    in_ctl   = '0;
    in_class = '0;
    repeat (C_RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_value("out_valid", 64'(out_valid), 64'd0);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("out_valid", 64'(out_valid), 64'd0);  // Still idle after reset

    test_special(C_N_SPEC);
    test_round(C_N_FP64, FMT_FP64, "fp64_round");
    test_round(C_N_FP32, FMT_FP32, "fp32_round");
    test_underflow(C_N_UF);
    test_trunc(C_N_TRUNC);
    test_pipeline(C_N_PIPE);

    repeat (4) @(posedge clk);
    $display("Tests: %0d  checks: %0d  errors: %0d", test_idx, checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verilog/fpnorm_pkg.sv ====
package fpnorm_pkg;

  //////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////
  localparam int unsigned C_MANT_FP64 = 52;
  localparam int unsigned C_EXP_FP64  = 11;
  localparam int unsigned C_MANT_FP32 = 23;
  localparam int unsigned C_EXP_FP32  = 8;

  localparam int unsigned C_MANT_W   = C_MANT_FP64 + 5;           // Hidden, fraction, 4 round bits
  localparam int unsigned C_EXP_W    = C_EXP_FP64 + 2;            // Signed, overflow headroom
  localparam int unsigned C_FP32_LSB = C_MANT_FP64 - C_MANT_FP32; // FP32 LSB in a 53b mantissa

  localparam logic [C_EXP_FP64:0]    C_EXP_ONE_FP64  = 12'd1;
  localparam logic [C_MANT_FP64-1:0] C_MANT_NAN_FP64 = 52'h8_0000_0000_0000; // Quiet bit only
  localparam logic [31:0]            C_FP32_BOX      = 32'hffff_ffff;

  //////////////////////////////////////////////////
  // Control and classification
  //////////////////////////////////////////////////
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP64 = 1'b1
  } fmt_e;

  typedef enum logic [2:0] {
    RM_NEAREST  = 3'b000,
    RM_TRUNC    = 3'b001,
    RM_MINUSINF = 3'b010,
    RM_PLUSINF  = 3'b011
  } rm_e;

  typedef struct packed {
    logic div_en;
    logic sqrt_en;
    rm_e  rm;
    logic full_precision;  // Low means truncate and raise NX
    fmt_e fmt;
  } op_ctl_t;

  typedef struct packed {
    logic inf_a;
    logic inf_b;
    logic zero_a;
    logic zero_b;
    logic nan_a;
    logic nan_b;
    logic snan;  // Either NaN is signalling
  } operand_class_t;

  typedef struct packed {
    logic [C_MANT_W-1:0]       mant;
    logic signed [C_EXP_W-1:0] exp;
    logic                      sign;
  } norm_in_t;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  //////////////////////////////////////////////////
  // Datapath payloads
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                   hit;   // Overrides normal processing
    logic [C_MANT_FP64:0]   mant;
    logic [C_EXP_FP64-1:0]  exp;   // All ones or all zeros
    logic                   sign;
    fflags_t                flags;
  } special_res_t;

  typedef struct packed {
    logic [C_MANT_FP64:0]   mant_norm;      // Hidden bit plus fraction
    logic [C_EXP_FP64-1:0]  exp_norm;
    logic [C_MANT_W-1:0]    mant_forround;  // Bits below the FP64 LSB
    logic                   sign;
    fflags_t                flags;          // NX added at pack
    rm_e                    rm;
    logic                   full_precision;
    fmt_e                   fmt;
  } norm_stage_t;

  typedef struct packed {
    logic [C_MANT_FP64-1:0] mant;
    logic [C_EXP_FP64-1:0]  exp;
    logic                   inexact;
  } rounded_t;

  typedef struct packed {
    logic                   sign;
    logic [C_EXP_FP64-1:0]  exp;
    logic [C_MANT_FP64-1:0] frac;
  } fp64_word_t;

  typedef struct packed {
    logic [31:0]            box;   // All ones when boxed
    logic                   sign;
    logic [C_EXP_FP32-1:0]  exp;
    logic [C_MANT_FP32-1:0] frac;
  } fp32_word_t;

  typedef union packed {
    fp64_word_t fp64;
    fp32_word_t fp32;
  } fp_result_u;

endpackage

// ==== verilog/norm_pack.sv ====
`timescale 1ns/100ps

module norm_pack import fpnorm_pkg::*;
(
  input  norm_stage_t norm,
  input  rounded_t    rnd,
  output fp_result_u  result,
  output fflags_t     fflags
);

  logic [C_MANT_FP64-1:0] mant_sel;  // Hidden bit dropped
  logic [C_EXP_FP64-1:0]  exp_sel;

  // Truncating mode skips the rounder
  assign mant_sel = norm.full_precision ? rnd.mant : norm.mant_norm[C_MANT_FP64-1:0];
  assign exp_sel  = norm.full_precision ? rnd.exp  : norm.exp_norm;

  always_comb
  begin
    if (norm.fmt == FMT_FP32)
    begin
      result.fp32.box  = C_FP32_BOX;                          // NaN boxing
      result.fp32.sign = norm.sign;
      result.fp32.exp  = exp_sel[C_EXP_FP32-1:0];
      result.fp32.frac = mant_sel[C_MANT_FP64-1 -: C_MANT_FP32];
    end
    else
    begin
      result.fp64.sign = norm.sign;
      result.fp64.exp  = exp_sel;
      result.fp64.frac = mant_sel;
    end
  end

  always_comb
  begin
    fflags    = norm.flags;                                   // NV, DZ, OF, UF from stage one
    fflags.nx = ~norm.full_precision | rnd.inexact;
  end

endmodule

// ==== verilog/norm_round.sv ====
`timescale 1ns/100ps

module norm_round import fpnorm_pkg::*;
(
  input  norm_stage_t norm,
  output rounded_t    rnd
);

  logic [C_MANT_FP64:0]   mant_upper;    // Kept bits, LSB aligned per format
  logic [1:0]             mant_lower;    // Guard and round
  logic                   mant_sticky;
  logic                   mant_lsb;
  logic                   mant_rounded;  // Any dropped bit set
  logic                   round_up;
  logic [C_MANT_FP64:0]   round_vec;
  logic [C_MANT_FP64+1:0] mant_sum;
  logic                   renorm;        // Carry out of the hidden bit

  //////////////////////////////////////////////////
  // Rounding point select
  //////////////////////////////////////////////////
  always_comb
  begin
    if (norm.fmt == FMT_FP32)
    begin
      mant_upper  = {norm.mant_norm[C_MANT_FP64:C_FP32_LSB], {C_FP32_LSB{1'b0}}};
      mant_lower  = norm.mant_norm[C_FP32_LSB-1 -: 2];
      mant_sticky = |norm.mant_norm[C_FP32_LSB-3:0];
      mant_lsb    = norm.mant_norm[C_FP32_LSB];
    end
    else
    begin
      mant_upper  = norm.mant_norm;
      mant_lower  = norm.mant_forround[C_MANT_W-1 -: 2];
      mant_sticky = |norm.mant_forround[C_MANT_W-3:0];
      mant_lsb    = norm.mant_norm[0];
    end
  end

  assign mant_rounded = (|mant_lower) | mant_sticky;

  // Round-up decision
  always_comb
  begin
    case (norm.rm)
      RM_NEAREST:  round_up = mant_lower[1] & (mant_lower[0] | mant_sticky | mant_lsb);
      RM_PLUSINF:  round_up = mant_rounded & ~norm.sign;
      RM_MINUSINF: round_up = mant_rounded & norm.sign;
      default:     round_up = 1'b0;  // Truncate and unused codes
    endcase
  end

  //////////////////////////////////////////////////
  // Increment and renormalize
  //////////////////////////////////////////////////
  assign round_vec = (norm.fmt == FMT_FP32) ?
                     ((C_MANT_FP64+1)'(round_up) << C_FP32_LSB) :
                     (C_MANT_FP64+1)'(round_up);

  assign mant_sum = mant_upper + round_vec;
  assign renorm   = mant_sum[C_MANT_FP64+1];

  assign rnd.mant    = renorm ? mant_sum[C_MANT_FP64:1] : mant_sum[C_MANT_FP64-1:0];
  assign rnd.exp     = norm.exp_norm + C_EXP_FP64'(renorm);
  assign rnd.inexact = mant_rounded;

endmodule

// ==== verilog/norm_round_top.sv ====
`timescale 1ns/100ps

module norm_round_top import fpnorm_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  input  norm_in_t       in_data,
  input  op_ctl_t        in_ctl,
  input  operand_class_t in_class,
  output logic           out_valid,
  output fp_result_u     out_result,
  output fflags_t        out_fflags
);

  special_res_t spec;
  norm_stage_t  shift_out;
  norm_stage_t  s1_next;
  logic         s1_valid;
  norm_stage_t  s1_data;
  rounded_t     rnd;
  fp_result_u   pack_result;
  fflags_t      pack_fflags;

  //////////////////////////////////////////////////
  // Stage 1: classify and normalize
  //////////////////////////////////////////////////
  norm_special_case u_special (
    .sign (in_data.sign),
    .ctl  (in_ctl),
    .cls  (in_class),
    .spec (spec)
  );

  norm_shift u_shift (
    .din  (in_data),
    .fmt  (in_ctl.fmt),
    .spec (spec),
    .norm (shift_out)
  );

  // Attach rounding controls for stage 2
  always_comb
  begin
    s1_next                = shift_out;
    s1_next.rm             = in_ctl.rm;
    s1_next.full_precision = in_ctl.full_precision;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      s1_valid <= 1'b0;
    else
      s1_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
      s1_data <= s1_next;  // Payload only loads on valid
  end

  //////////////////////////////////////////////////
  // Stage 2: round and pack
  //////////////////////////////////////////////////
  norm_round u_round (
    .norm (s1_data),
    .rnd  (rnd)
  );

  norm_pack u_pack (
    .norm   (s1_data),
    .rnd    (rnd),
    .result (pack_result),
    .fflags (pack_fflags)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= s1_valid;
  end

  always_ff @(posedge clk)
  begin
    if (s1_valid)
    begin
      out_result <= pack_result;
      out_fflags <= pack_fflags;
    end
  end

endmodule

// ==== verilog/norm_shift.sv ====
`timescale 1ns/100ps

module norm_shift import fpnorm_pkg::*;
(
  input  norm_in_t     din,
  input  fmt_e         fmt,
  input  special_res_t spec,
  output norm_stage_t  norm
);

  logic [C_EXP_W-1:0]   rs_amount;  // Right shift for negative exponents
  logic [C_MANT_FP64:0] rs_mant;
  logic [C_MANT_W-1:0]  rs_sticky;  // Bits shifted out
  logic [C_EXP_W-1:0]   exp_dec;
  logic                 mant_msb;
  logic                 exp_of;     // Format overflow bit
  logic                 exp_max;    // Format exponent field all ones

  assign rs_amount = ~din.exp + C_EXP_W'(2);  // Magnitude plus one
  assign {rs_mant, rs_sticky} = {din.mant, {(C_MANT_FP64+1){1'b0}}} >> rs_amount;

  assign exp_dec  = din.exp - 1'b1;
  assign mant_msb = din.mant[C_MANT_W-1];

  assign exp_of  = (fmt == FMT_FP32) ? din.exp[C_EXP_FP32] : din.exp[C_EXP_FP64];
  assign exp_max = (fmt == FMT_FP32) ? (&din.exp[C_EXP_FP32-1:0]) :
                                       (&din.exp[C_EXP_FP64-1:0]);

  always_comb
  begin
    norm.mant_norm      = '0;
    norm.exp_norm       = '0;
    norm.mant_forround  = '0;
    norm.sign           = din.sign;
    norm.flags          = '0;
    norm.rm             = RM_TRUNC;  // Rounding controls attached by the top
    norm.full_precision = 1'b0;
    norm.fmt            = fmt;

    if (din.exp[C_EXP_FP64:0] == '0)
    begin
      if (din.mant != '0)            // Denormal, true zero keeps defaults
      begin
        norm.mant_norm     = {1'b0, din.mant[C_MANT_W-1:5]};
        norm.mant_forround = {din.mant[4:0], {C_MANT_FP64{1'b0}}};
        norm.flags.uf      = 1'b1;
      end
    end
    else if ((din.exp[C_EXP_FP64:0] == C_EXP_ONE_FP64) && !mant_msb)
    begin
      norm.mant_norm     = din.mant[C_MANT_W-1:4];    // Denormal, shift by four
      norm.mant_forround = {din.mant[3:0], {(C_MANT_FP64+1){1'b0}}};
      norm.flags.uf      = 1'b1;
    end
    else if (din.exp[C_EXP_W-1])
    begin
      norm.mant_norm     = rs_mant;                   // Negative exponent
      norm.mant_forround = rs_sticky;
      norm.flags.uf      = 1'b1;
    end
    else if (exp_of || (exp_max && mant_msb))
    begin
      norm.exp_norm = '1;                             // Infinity
      norm.flags.of = 1'b1;
    end
    else if (mant_msb)
    begin
      norm.mant_norm     = din.mant[C_MANT_W-1:4];    // 1.x
      norm.exp_norm      = din.exp[C_EXP_FP64-1:0];
      norm.mant_forround = {din.mant[3:0], {(C_MANT_FP64+1){1'b0}}};
    end
    else
    begin
      // 0.1x, also covers the all-ones exponent
      norm.mant_norm     = din.mant[C_MANT_W-2:3];
      norm.exp_norm      = exp_dec[C_EXP_FP64-1:0];
      norm.mant_forround = {din.mant[2:0], {(C_MANT_FP64+2){1'b0}}};
    end

    // Special cases win over everything above
    if (spec.hit)
    begin
      norm.mant_norm     = spec.mant;
      norm.exp_norm      = spec.exp;
      norm.mant_forround = '0;
      norm.sign          = spec.sign;
      norm.flags         = spec.flags;
    end
  end

endmodule

// ==== verilog/norm_special_case.sv ====
`timescale 1ns/100ps

module norm_special_case import fpnorm_pkg::*;
(
  input  logic           sign,
  input  op_ctl_t        ctl,
  input  operand_class_t cls,
  output special_res_t   spec
);

  logic div_inf_b;   // x / inf
  logic div_zero_b;  // x / 0
  logic sqrt_neg;    // Square root of a negative operand

  assign div_inf_b  = ctl.div_en & cls.inf_b;
  assign div_zero_b = ctl.div_en & cls.zero_b;
  assign sqrt_neg   = ctl.sqrt_en & sign;

  // Priority chain, first match wins
  always_comb
  begin
    spec.hit   = 1'b1;                        // Cleared at the bottom of the chain
    spec.mant  = {1'b0, C_MANT_NAN_FP64};     // Canonical quiet NaN
    spec.exp   = '1;
    spec.sign  = 1'b0;
    spec.flags = '0;

    if (cls.nan_a || cls.nan_b)
    begin
      spec.flags.nv = cls.snan;               // Quiet NaNs pass silently
    end
    else if (cls.inf_a)
    begin
      if (div_inf_b || sqrt_neg)              // inf/inf, sqrt(-inf)
      begin
        spec.flags.nv = 1'b1;
      end
      else
      begin
        spec.mant     = '0;                   // Signed infinity
        spec.sign     = sign;
        spec.flags.of = 1'b1;
      end
    end
    else if (div_inf_b)
    begin
      spec.mant     = '0;                     // Finite / inf goes to zero
      spec.exp      = '0;
      spec.sign     = sign;
      spec.flags.of = 1'b1;
    end
    else if (cls.zero_a)
    begin
      if (ctl.div_en)
      begin
        spec.flags.nv = 1'b1;                 // NaN result either way
        spec.flags.dz = ~cls.zero_b;          // 0/0 gives no DZ
      end
      else
      begin
        spec.mant = '0;                       // Signed zero
        spec.exp  = '0;
        spec.sign = sign;
      end
    end
    else if (div_zero_b)
    begin
      spec.mant     = '0;                     // x/0 is signed infinity
      spec.sign     = sign;
      spec.flags.dz = 1'b1;
    end
    else if (sqrt_neg)
    begin
      spec.flags.nv = 1'b1;
    end
    else
    begin
      spec.hit = 1'b0;                        // Finite value, normal path
    end
  end

endmodule
